/* src/dp_vid_pkg.sv */
/*
    Shared widths, bus structs and lane order for the video clock datapath.
    Modules import it inside their body and use scoped names in their ports.
*/

`default_nettype none

package dp_vid_pkg;

    // Video
    localparam int PPC    = 4;              // Pixels per clock
    localparam int BPC    = 8;              // Bits per component
    localparam int COMP_W = PPC * BPC;      // One color over all pixels

    // One video beat of 99 bits
    typedef struct packed {
        logic              vs;
        logic              hs;
        logic              de;
        logic [COMP_W-1:0] r;
        logic [COMP_W-1:0] g;
        logic [COMP_W-1:0] b;
    } vid_beat_t;

    // Link
    localparam int LANES = 4;
    localparam int SPL   = 4;               // Symbols per lane

    // One link symbol with the data byte in the low bits as the DPTX core emits it
    typedef struct packed {
        logic       disp_ctl;               // 0 automatic / 1 force
        logic       disp_val;               // 0 negative / 1 positive
        logic       k;                      // Control symbol
        logic [7:0] dat;
    } lnk_sym_t;

    // Lane major with lane 0 symbol 0 at bit 0
    typedef lnk_sym_t [LANES-1:0][SPL-1:0] lnk_bus_t;

    // Serdes word geometry
    localparam int PHY_W        = 80;
    localparam int SYM_STRIDE   = 10;       // Each symbol in a 10 bit slot
    localparam int DISP_CTL_LSB = 40;
    localparam int DISP_VAL_LSB = 44;

    typedef logic [PHY_W-1:0] phy_word_t;
    typedef phy_word_t [LANES-1:0] phy_bus_t;

    // DP lane carried by each serdes channel; lanes 0 and 1 swap on the board
    localparam int LANE_ORDER [LANES] = '{1, 0, 2, 3};

    // Port register
    localparam int CTL_W = 8;

    typedef struct packed {
        logic vid_sel;                      // 1 camera / 0 colorbar
        logic lnk_rst;
        logic clk_sel;
    } ctl_t;

    typedef struct packed {
        logic sw1;
        logic sw0;
        logic phy_rdy;
        logic vid_lock;
        logic gt_lock;
    } sts_t;

    // Heartbeat half period at the video clock
    localparam int unsigned HB_BEAT_VID = 67_500_000;

endpackage

`default_nettype wire

/* src/dp_ctl_regs.sv */
/*
    Port register for the video clock domain.
    A write strobe loads the steering bits; status inputs are sampled
    every clock with the switches inverted and the serdes ready bits merged.
*/

`timescale 1ns/1ns
`default_nettype none

module dp_ctl_regs
(
    input  wire logic                        clk_from_vid_buf,
    input  wire logic                        SYS_RSTN_IN,

    // Port write
    input  wire logic                        ctl_wr_i,
    input  wire logic [dp_vid_pkg::CTL_W-1:0] ctl_dat_i,

    // Status sources
    input  wire logic                        gt_lock_i,
    input  wire logic                        vid_lock_i,
    input  wire logic [3:0]                  phy_rdy_i,      // One per serdes channel
    input  wire logic [1:0]                  sw_i,           // Active low switches

    output dp_vid_pkg::ctl_t                 ctl_o,
    output dp_vid_pkg::sts_t                 sts_o
);

    import dp_vid_pkg::*;

    // Steering bits with the upper data bits ignored
    always_ff @(posedge clk_from_vid_buf)
    begin
        if (!SYS_RSTN_IN)
        begin
            ctl_o <= '0;
        end
        else if (ctl_wr_i)
        begin
            ctl_o <= ctl_t'(ctl_dat_i[$bits(ctl_t)-1:0]);
        end
    end

    // Status sample
    always_ff @(posedge clk_from_vid_buf)
    begin
        if (!SYS_RSTN_IN)
        begin
            sts_o <= '0;
        end
        else
        begin
            sts_o.gt_lock  <= gt_lock_i;
            sts_o.vid_lock <= vid_lock_i;
            sts_o.phy_rdy  <= &phy_rdy_i;     // All channels up
            sts_o.sw0      <= ~sw_i[0];
            sts_o.sw1      <= ~sw_i[1];
        end
    end

    // A write must carry defined data, else the mux and link reset go unknown
    property p_wr_known;
        @(posedge clk_from_vid_buf) disable iff (!SYS_RSTN_IN)
            ctl_wr_i |-> !$isunknown(ctl_dat_i);
    endproperty

    a_wr_known : assert property (p_wr_known)
        else $error("Port write with unknown data");

endmodule

`default_nettype wire

/* src/dp_vid_mux.sv */
/*
    Registered video source mux.
    The select bit comes from the port register and passes two flops first,
    so a new source reaches the output three edges after the register changes.
*/

`timescale 1ns/1ns
`default_nettype none

module dp_vid_mux
(
    input  wire logic             clk_from_vid_buf,
    input  wire logic             SYS_RSTN_IN,

    input  wire logic             vid_sel_i,     // 1 camera / 0 colorbar
    input  dp_vid_pkg::vid_beat_t cam_i,         // Scaled camera stream
    input  dp_vid_pkg::vid_beat_t bar_i,         // Colorbar stream
    output dp_vid_pkg::vid_beat_t vid_o
);

    import dp_vid_pkg::*;

    logic sel_meta;
    logic sel_sync;

    // Select synchronizer
    always_ff @(posedge clk_from_vid_buf)
    begin
        if (!SYS_RSTN_IN)
        begin
            sel_meta <= 1'b0;
            sel_sync <= 1'b0;
        end
        else
        begin
            sel_meta <= vid_sel_i;
            sel_sync <= sel_meta;
        end
    end

    // Output register
    always_ff @(posedge clk_from_vid_buf)
    begin
        if (!SYS_RSTN_IN)
            vid_o <= '0;
        else if (sel_sync)
            vid_o <= cam_i;         // Camera
        else
            vid_o <= bar_i;         // Colorbar
    end

    // Downstream sees a blank beat on the first cycle out of reset
    property p_vid_clear;
        @(posedge clk_from_vid_buf)
            $rose(SYS_RSTN_IN) |-> (vid_o == vid_beat_t'('0));
    endproperty

    a_vid_clear : assert property (p_vid_clear)
        else $error("Video output not clear after reset");

endmodule

`default_nettype wire

/* src/dp_lane_map.sv */
/*
    Packs the DP link symbols into the four serdes transmit words.
    Each channel takes the lane named in the lane order table, places the
    K bit and data of each symbol on a 10 bit stride and gathers the
    disparity bits in the middle of the word. Link reset blanks the output.
*/

`timescale 1ns/1ns
`default_nettype none

module dp_lane_map
(
    input  wire logic            clk_from_vid_buf,
    input  wire logic            SYS_RSTN_IN,

    input  wire logic            lnk_rst_i,       // Hold words at zero
    input  dp_vid_pkg::lnk_bus_t lnk_i,           // From the DPTX link
    output dp_vid_pkg::phy_bus_t phy_o            // To the serdes channels
);

    import dp_vid_pkg::*;

    phy_bus_t phy_nxt;

    // Word packing
    always_comb
    begin : pack
        lnk_sym_t sym;
        int       lane;

        phy_nxt = '0;                           // Unused upper bits stay zero
        sym     = '0;
        lane    = 0;

        for (int ch = 0; ch < LANES; ch++)
        begin
            lane = LANE_ORDER[ch];

            for (int s = 0; s < SPL; s++)
            begin
                sym = lnk_i[lane][s];

                // K bit just above the data byte
                phy_nxt[ch][s*SYM_STRIDE +: 9] = {sym.k, sym.dat};

                phy_nxt[ch][DISP_CTL_LSB + s] = sym.disp_ctl;
                phy_nxt[ch][DISP_VAL_LSB + s] = sym.disp_val;
            end
        end
    end

    // Output register
    always_ff @(posedge clk_from_vid_buf)
    begin
        if (!SYS_RSTN_IN)
        begin
            phy_o <= '0;
        end
        else if (lnk_rst_i)
        begin
            phy_o <= '0;        // Link held in reset
        end
        else
        begin
            phy_o <= phy_nxt;
        end
    end

    // Serdes ignores the top of the word, so nothing may ever land there
    for (genvar ch = 0; ch < LANES; ch++)
    begin : g_upper_chk
        property p_upper_zero;
            @(posedge clk_from_vid_buf) disable iff (!SYS_RSTN_IN)
                phy_o[ch][PHY_W-1:DISP_VAL_LSB+SPL] == '0;
        endproperty

        a_upper_zero : assert property (p_upper_zero)
            else $error("Serdes channel %0d upper bits not zero", ch);
    end

endmodule

`default_nettype wire

/* src/dp_heartbeat.sv */
/*
    Heartbeat LED for the video clock.
    The LED toggles every hb_beat clocks, so a running clock blinks visibly.
*/

`timescale 1ns/1ns
`default_nettype none

module dp_heartbeat
#(
    parameter int unsigned hb_beat = dp_vid_pkg::HB_BEAT_VID   // Half period in clocks
)
(
    input  wire logic clk_from_vid_buf,
    input  wire logic SYS_RSTN_IN,
    output logic      led_o
);

    localparam int unsigned         CNT_W    = $clog2(hb_beat + 1);
    localparam logic [CNT_W-1:0]    CNT_LAST = CNT_W'(hb_beat - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk_from_vid_buf)
    begin
        if (!SYS_RSTN_IN)
        begin
            cnt   <= '0;
            led_o <= 1'b0;
        end
        else if (cnt == CNT_LAST)
        begin
            cnt   <= '0;                // Restart
            led_o <= ~led_o;
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/dp_rpi_vid_top.sv */
/*
    Video clock part of the DisplayPort camera design.
    The port register steers the source mux and the link to serdes mapper;
    a heartbeat shows that the video clock runs.
*/

`timescale 1ns/1ns
`default_nettype none

module dp_rpi_vid_top
#(
    parameter int unsigned hb_beat = dp_vid_pkg::HB_BEAT_VID
)
(
    input  wire logic                         clk_from_vid_buf,
    input  wire logic                         SYS_RSTN_IN,

    // Port register
    input  wire logic                         ctl_wr_i,
    input  wire logic [dp_vid_pkg::CTL_W-1:0] ctl_dat_i,

    // Status
    input  wire logic                         gt_lock_i,
    input  wire logic                         vid_lock_i,
    input  wire logic [3:0]                   phy_rdy_i,
    input  wire logic [1:0]                   sw_i,

    // Video sources
    input  dp_vid_pkg::vid_beat_t             cam_i,
    input  dp_vid_pkg::vid_beat_t             bar_i,

    // Link symbols
    input  dp_vid_pkg::lnk_bus_t              lnk_i,

    output logic                              clk_sel_o,     // Board clock select
    output dp_vid_pkg::sts_t                  sts_o,
    output dp_vid_pkg::vid_beat_t             vid_o,
    output dp_vid_pkg::phy_bus_t              phy_o,
    output logic                              led_o
);

    import dp_vid_pkg::*;

    ctl_t ctl;

    dp_ctl_regs i_ctl_regs
    (
        .clk_from_vid_buf (clk_from_vid_buf),
        .SYS_RSTN_IN      (SYS_RSTN_IN),
        .ctl_wr_i         (ctl_wr_i),
        .ctl_dat_i        (ctl_dat_i),
        .gt_lock_i        (gt_lock_i),
        .vid_lock_i       (vid_lock_i),
        .phy_rdy_i        (phy_rdy_i),
        .sw_i             (sw_i),
        .ctl_o            (ctl),
        .sts_o            (sts_o)
    );

    assign clk_sel_o = ctl.clk_sel;

    dp_vid_mux i_vid_mux
    (
        .clk_from_vid_buf (clk_from_vid_buf),
        .SYS_RSTN_IN      (SYS_RSTN_IN),
        .vid_sel_i        (ctl.vid_sel),
        .cam_i            (cam_i),
        .bar_i            (bar_i),
        .vid_o            (vid_o)
    );

    dp_lane_map i_lane_map
    (
        .clk_from_vid_buf (clk_from_vid_buf),
        .SYS_RSTN_IN      (SYS_RSTN_IN),
        .lnk_rst_i        (ctl.lnk_rst),
        .lnk_i            (lnk_i),
        .phy_o            (phy_o)
    );

    dp_heartbeat
    #(
        .hb_beat (hb_beat)
    )
    i_vid_hb
    (
        .clk_from_vid_buf (clk_from_vid_buf),
        .SYS_RSTN_IN      (SYS_RSTN_IN),
        .led_o            (led_o)
    );

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
/*
    Testbench clock and reset source.
    Reset is held low for a number of clock cycles, then released on a rising edge.
*/

`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen
#(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 4
)
(
    output logic clk_o,
    output logic rstn_o
);

    initial
    begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial
    begin
        rstn_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rstn_o <= 1'b1;              // Release with the clock edge
    end

endmodule

`default_nettype wire

/* verif/tb_dp_rpi_vid.sv */
/*
    Table-driven testbench for the video clock top level.
    Builds a random stimulus table with expected values, applies one entry per
    clock and checks port register, status, source mux, lane mapping and heartbeat.
*/

`timescale 1ns/1ns
`default_nettype none

module tb_dp_rpi_vid;

    import dp_vid_pkg::*;

    localparam int PERIOD_NS      = 40;
    localparam int RST_CYCLES     = 4;
    localparam int HB_BEAT        = 8;
    localparam int N_ENTRIES      = 64;
    localparam int CYC_PER_ENTRY  = 1;
    localparam int MARGIN_CYC     = 40;
    localparam int WATCHDOG_NS    =
        (RST_CYCLES + N_ENTRIES * CYC_PER_ENTRY + MARGIN_CYC) * PERIOD_NS;

    // One table row with stimulus and expected values
    typedef struct packed {
        logic       wr;
        logic [7:0] dat;
        logic       gt_lock;
        logic       vid_lock;
        logic [3:0] phy_rdy;
        logic [1:0] sw;
        vid_beat_t  cam;
        vid_beat_t  bar;
        lnk_bus_t   lnk;
        logic       exp_clk_sel;
        sts_t       exp_sts;
        logic       exp_cam;        // Camera expected on vid_o
        logic       exp_lnk_rst;    // Link reset seen by the mapper
    } entry_t;

    logic                 clk_from_vid_buf;
    logic                 SYS_RSTN_IN;
    logic                 ctl_wr_i;
    logic [CTL_W-1:0]     ctl_dat_i;
    logic                 gt_lock_i;
    logic                 vid_lock_i;
    logic [3:0]           phy_rdy_i;
    logic [1:0]           sw_i;
    vid_beat_t            cam_i;
    vid_beat_t            bar_i;
    lnk_bus_t             lnk_i;
    logic                 clk_sel_o;
    sts_t                 sts_o;
    vid_beat_t            vid_o;
    phy_bus_t             phy_o;
    logic                 led_o;

    entry_t               stim [N_ENTRIES];

    int                   hb_cyc     = 0;
    int                   hb_last    = 0;
    int                   hb_toggles = 0;
    logic                 led_prev   = 1'b0;

    tb_clk_gen #(.PERIOD_NS(PERIOD_NS), .RST_CYCLES(RST_CYCLES)) i_clk_gen
    (
        .clk_o  (clk_from_vid_buf),
        .rstn_o (SYS_RSTN_IN)
    );

    dp_rpi_vid_top #(.hb_beat(HB_BEAT)) i_dut
    (
        .clk_from_vid_buf (clk_from_vid_buf),
        .SYS_RSTN_IN      (SYS_RSTN_IN),
        .ctl_wr_i         (ctl_wr_i),
        .ctl_dat_i        (ctl_dat_i),
        .gt_lock_i        (gt_lock_i),
        .vid_lock_i       (vid_lock_i),
        .phy_rdy_i        (phy_rdy_i),
        .sw_i             (sw_i),
        .cam_i            (cam_i),
        .bar_i            (bar_i),
        .lnk_i            (lnk_i),
        .clk_sel_o        (clk_sel_o),
        .sts_o            (sts_o),
        .vid_o            (vid_o),
        .phy_o            (phy_o),
        .led_o            (led_o)
    );

    task automatic check_equal(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        if (got !== exp)
        begin
            $display("Fail at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "Value mismatch");
        end
    endtask

    function automatic vid_beat_t random_beat();
        int unsigned r;
        vid_beat_t   beat;
        r         = $urandom();
        beat.vs   = r[0];
        beat.hs   = r[1];
        beat.de   = r[2];
        beat.r    = $urandom();
        beat.g    = $urandom();
        beat.b    = $urandom();
        return beat;
    endfunction

    function automatic lnk_bus_t random_link();
        int unsigned r;
        lnk_bus_t    bus;
        for (int l = 0; l < LANES; l++)
        begin
            for (int s = 0; s < SPL; s++)
            begin
                r                  = $urandom();
                bus[l][s].dat      = r[7:0];
                bus[l][s].k        = r[8];
                bus[l][s].disp_val = r[9];
                bus[l][s].disp_ctl = r[10];
            end
        end
        return bus;
    endfunction

    // Board swaps DP lanes 0 and 1
    function automatic int lane_of_channel(input int ch);
        case (ch)
            0:       return 1;
            1:       return 0;
            default: return ch;
        endcase
    endfunction

    function automatic phy_bus_t pack_words(input lnk_bus_t l);
        phy_bus_t w;
        int       lane;
        w = '0;
        for (int ch = 0; ch < LANES; ch++)
        begin
            lane = lane_of_channel(ch);
            for (int s = 0; s < SPL; s++)
            begin
                w[ch][s*SYM_STRIDE +: 8]  = l[lane][s].dat;
                w[ch][s*SYM_STRIDE + 8]   = l[lane][s].k;
                w[ch][DISP_CTL_LSB + s]   = l[lane][s].disp_ctl;
                w[ch][DISP_VAL_LSB + s]   = l[lane][s].disp_val;
            end
        end
        return w;
    endfunction

    function automatic sts_t expected_status(input logic gt, input logic vl,
                                             input logic [3:0] rdy, input logic [1:0] sw);
        sts_t s;
        s.gt_lock  = gt;
        s.vid_lock = vl;
        s.phy_rdy  = (rdy == 4'hF);
        s.sw0      = ~sw[0];        // Switches are active low
        s.sw1      = ~sw[1];
        return s;
    endfunction

    task automatic build_stimulus();
        logic [2:0]  reg_val;
        logic [2:0]  reg_hist [N_ENTRIES];
        int unsigned r;
        entry_t      e;
        reg_val = 3'b000;
        for (int i = 0; i < N_ENTRIES; i++)
        begin
            r     = $urandom();
            e     = '0;
            e.wr  = (r[2:0] == 3'd0);
            e.dat = 8'($urandom());
            if (i == 2)
            begin
                e.wr  = 1'b1;
                e.dat = 8'h05;      // Camera and clock select
            end
            else if (i == 12)
            begin
                e.wr  = 1'b1;
                e.dat = 8'h02;      // Link reset and back to colorbar
            end
            else if (i == 20)
            begin
                e.wr  = 1'b1;
                e.dat = 8'h04;
            end
            e.gt_lock  = r[8];
            e.vid_lock = r[9];
            e.phy_rdy  = r[10] ? 4'hF : r[14:11];
            e.sw       = r[16:15];
            e.cam      = random_beat();
            e.bar      = random_beat();
            e.lnk      = random_link();
            if (e.wr)
                reg_val = e.dat[2:0];
            reg_hist[i]   = reg_val;
            e.exp_clk_sel = reg_val[0];
            if (i > 0)
                e.exp_lnk_rst = reg_hist[i-1][1];
            if (i >= 3)
                e.exp_cam = reg_hist[i-3][2];   // Register, two sync flops, output flop
            e.exp_sts = expected_status(e.gt_lock, e.vid_lock, e.phy_rdy, e.sw);
            stim[i]   = e;
        end
    endtask

    task automatic drive_entry(input int i);
        ctl_wr_i   <= stim[i].wr;
        ctl_dat_i  <= stim[i].dat;
        gt_lock_i  <= stim[i].gt_lock;
        vid_lock_i <= stim[i].vid_lock;
        phy_rdy_i  <= stim[i].phy_rdy;
        sw_i       <= stim[i].sw;
        cam_i      <= stim[i].cam;
        bar_i      <= stim[i].bar;
        lnk_i      <= stim[i].lnk;
    endtask

    task automatic check_entry(input int i);
        entry_t    e;
        vid_beat_t exp_vid;
        phy_bus_t  exp_phy;
        e       = stim[i];
        exp_vid = e.exp_cam ? e.cam : e.bar;
        exp_phy = e.exp_lnk_rst ? '0 : pack_words(e.lnk);
        check_equal(128'(clk_sel_o), 128'(e.exp_clk_sel), $sformatf("entry %0d clk_sel_o", i));
        check_equal(128'(sts_o), 128'(e.exp_sts), $sformatf("entry %0d sts_o", i));
        check_equal(128'(vid_o), 128'(exp_vid), $sformatf("entry %0d vid_o", i));
        for (int ch = 0; ch < LANES; ch++)
        begin
            check_equal(128'(phy_o[ch]), 128'(exp_phy[ch]),
                        $sformatf("entry %0d phy_o[%0d]", i, ch));
        end
    endtask

    // LED edge spacing
    always @(negedge clk_from_vid_buf)
    begin
        if (SYS_RSTN_IN)
        begin
            hb_cyc = hb_cyc + 1;
            if (led_o !== led_prev)
            begin
                if (hb_toggles > 0)
                    check_equal(128'(hb_cyc - hb_last), 128'(HB_BEAT), "led_o toggle spacing");
                hb_last    = hb_cyc;
                hb_toggles = hb_toggles + 1;
                led_prev   = led_o;
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Run timed out after %0d ns without finishing the table", WATCHDOG_NS);
        $display("=== FAIL ===");
        $fatal(1, "Watchdog expired");
    end

    initial
    begin
        int unsigned seed_ret;
        seed_ret   = $urandom(86);

        // Busy inputs while reset is held
        ctl_wr_i   = 1'b1;
        ctl_dat_i  = 8'h07;
        gt_lock_i  = 1'b1;
        vid_lock_i = 1'b1;
        phy_rdy_i  = 4'hF;
        sw_i       = 2'b00;         // Switches pressed
        cam_i      = '1;
        bar_i      = '1;
        lnk_i      = '1;
        build_stimulus();

        @(posedge SYS_RSTN_IN);
        ctl_wr_i   <= 1'b0;         // Idle from the first clock out of reset
        ctl_dat_i  <= '0;
        gt_lock_i  <= 1'b0;
        vid_lock_i <= 1'b0;
        phy_rdy_i  <= 4'h0;
        sw_i       <= 2'b11;        // Switches released
        cam_i      <= '0;
        bar_i      <= '0;
        lnk_i      <= '0;

        // First cycle out of reset holds the reset values
        @(negedge clk_from_vid_buf);
        check_equal(128'(clk_sel_o), 128'(0), "clk_sel_o after reset");
        check_equal(128'(sts_o), 128'(0), "sts_o after reset");
        check_equal(128'(vid_o), 128'(0), "vid_o after reset");
        for (int ch = 0; ch < LANES; ch++)
            check_equal(128'(phy_o[ch]), 128'(0), $sformatf("phy_o[%0d] after reset", ch));
        check_equal(128'(led_o), 128'(0), "led_o after reset");

        for (int i = 0; i < N_ENTRIES; i++)
        begin
            @(posedge clk_from_vid_buf);
            drive_entry(i);
            @(negedge clk_from_vid_buf);
            if (i > 0)
                check_entry(i - 1);
        end
        @(posedge clk_from_vid_buf);
        ctl_wr_i <= 1'b0;
        @(negedge clk_from_vid_buf);
        check_entry(N_ENTRIES - 1);

        check_equal(128'(hb_toggles >= 3), 128'(1), "heartbeat toggle count");
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
src/dp_vid_pkg.sv
src/dp_ctl_regs.sv
src/dp_vid_mux.sv
src/dp_lane_map.sv
src/dp_heartbeat.sv
src/dp_rpi_vid_top.sv
verif/tb_clk_gen.sv
verif/tb_dp_rpi_vid.sv

/* Makefile */
# Verilator build and run for the video clock testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_dp_rpi_vid
FILELIST  := compile.f
OBJ_DIR   := obj_dir

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard src/*.sv verif/*.sv)

.PHONY: all run clean

all: $(SIM)

# Rebuild only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
